// File: src/icache_pkg.sv
/*
 * instruction cache package
 * line and set geometry plus the state types of the two FSMs
 */

package icache_pkg;

    // ****************************************
    // address and data geometry
    // ****************************************
    localparam int unsigned CPU_AW   = 30; // cpu word address
    localparam int unsigned DATA_W   = 32; // one instruction
    localparam int unsigned OFFSET_W = 2;  // word inside a line

    localparam int unsigned WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int unsigned LINE_W         = WORDS_PER_LINE * DATA_W;

    // ****************************************
    // set associativity
    // ****************************************
    localparam int unsigned NUM_SETS_LOG2 = 6;
    localparam int unsigned NUM_SETS      = 1 << NUM_SETS_LOG2;
    localparam int unsigned INDEX_W       = NUM_SETS_LOG2;
    localparam int unsigned NUM_WAYS      = 2;

    localparam int unsigned TAG_W  = CPU_AW - INDEX_W - OFFSET_W;
    localparam int unsigned MEM_AW = CPU_AW - OFFSET_W; // line address on the memory bus

    // front end FSM
    typedef enum logic [1:0] {
        RUNNING,     // hits and decisions
        WAIT_MEMORY, // cpu stalled until the line is back
        REFILL       // cycle after the fill, stores may be stale
    } cache_state_e;

    // memory side FSM
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_ACK
    } refill_state_e;

endpackage

// File: src/icache_refill.sv
/*
 * refill machine of the instruction cache
 * issues one line read on the memory bus and hands the line back to the front end
 */

`timescale 1ns/10ps

module icache_refill import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,

    input  logic              fill_req_i,
    input  logic [MEM_AW-1:0] fill_addr_i,
    output logic              fill_done_o,
    output logic [LINE_W-1:0] fill_line_o,

    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic [MEM_AW-1:0] mem_addr_o,
    input  logic              mem_stall_i,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_rdata_i
);

    refill_state_e     state_q, state_d;
    logic [MEM_AW-1:0] addr_q;
    logic [LINE_W-1:0] line_q;
    logic              done_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:     if (fill_req_i)   state_d = REQUEST;
            REQUEST:  if (!mem_stall_i) state_d = WAIT_ACK; // request taken
            WAIT_ACK: if (mem_ack_i)    state_d = IDLE;
            default:                    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == WAIT_ACK) && mem_ack_i;
        end
    end

    // line address and returned line
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && fill_req_i) begin
            addr_q <= fill_addr_i;
        end
        if (state_q == WAIT_ACK && mem_ack_i) begin
            line_q <= mem_rdata_i; // held until the next fill
        end
    end

    assign mem_cyc_o   = (state_q != IDLE);
    assign mem_stb_o   = (state_q == REQUEST);
    assign mem_addr_o  = addr_q;
    assign fill_done_o = done_q;
    assign fill_line_o = line_q;

endmodule

// File: src/icache_top.sv
/*
 * instruction cache top level
 * front end and refill machine between the cpu fetch port and memory
 */

`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,

    // cpu fetch port
    input  logic              cpu_cyc_i,
    input  logic              cpu_stb_i,
    input  logic [CPU_AW-1:0] cpu_addr_i,
    output logic              cpu_stall_o,
    output logic              cpu_ack_o,
    output logic [DATA_W-1:0] cpu_rdata_o,

    // backing memory
    output logic              mem_cyc_o,
    output logic              mem_stb_o,
    output logic [MEM_AW-1:0] mem_addr_o,
    input  logic              mem_stall_i,
    input  logic              mem_ack_i,
    input  logic [LINE_W-1:0] mem_rdata_i,

    input  logic              flush_i
);

    logic              fill_req;
    logic [MEM_AW-1:0] fill_addr;
    logic              fill_done;
    logic [LINE_W-1:0] fill_line;

    instruction_cache i_cache (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .cpu_cyc_i   (cpu_cyc_i),
        .cpu_stb_i   (cpu_stb_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_stall_o (cpu_stall_o),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .fill_req_o  (fill_req),
        .fill_addr_o (fill_addr),
        .fill_done_i (fill_done),
        .fill_line_i (fill_line)
    );

    icache_refill i_refill (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .fill_req_i  (fill_req),
        .fill_addr_i (fill_addr),
        .fill_done_o (fill_done),
        .fill_line_o (fill_line),
        .mem_cyc_o   (mem_cyc_o),
        .mem_stb_o   (mem_stb_o),
        .mem_addr_o  (mem_addr_o),
        .mem_stall_i (mem_stall_i),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// File: src/icache_valid_store.sv
/*
 * valid flags of the instruction cache
 * one flag per set and way, both ways read together, one way written at a time
 */

`timescale 1ns/10ps

module icache_valid_store import icache_pkg::*; (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,

    input  logic                re_i,
    input  logic [INDEX_W-1:0]  raddr_i,
    output logic [NUM_WAYS-1:0] rdata_o,

    input  logic [NUM_WAYS-1:0] we_i,
    input  logic [INDEX_W-1:0]  waddr_i,
    input  logic                wdata_i
);

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] rdata_q;

    // flags, cleared by reset and by flush
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '{default: '0};
        end else if (flush_i) begin
            valid_q <= '{default: '0}; // fence, every line is gone
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (we_i[w]) begin
                    valid_q[waddr_i][w] <= wdata_i;
                end
            end
        end
    end

    // registered read of the whole set
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rdata_q <= '0;
        end else if (re_i) begin
            rdata_q <= valid_q[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: src/instruction_cache.sv
/*
 * instruction cache front end
 * 2-way set associative, hits acked one cycle after the request,
 * misses stall the cpu and restart early from the fetched line
 */

`timescale 1ns/10ps

module instruction_cache import icache_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,

    input  logic              cpu_cyc_i,
    input  logic              cpu_stb_i,
    input  logic [CPU_AW-1:0] cpu_addr_i,
    output logic              cpu_stall_o,
    output logic              cpu_ack_o,
    output logic [DATA_W-1:0] cpu_rdata_o,

    output logic              fill_req_o,
    output logic [MEM_AW-1:0] fill_addr_o,
    input  logic              fill_done_i,
    input  logic [LINE_W-1:0] fill_line_i
);

    cache_state_e        state_q, state_d;
    logic                req_d, req_q;          // request accepted / decision pending
    logic [CPU_AW-1:0]   cpu_addr_q;
    logic [TAG_W-1:0]    tag_q;
    logic [INDEX_W-1:0]  index_d, index_q;
    logic [OFFSET_W-1:0] offset_q;

    logic [TAG_W-1:0]    tag_rdata  [NUM_WAYS];
    logic [LINE_W-1:0]   line_rdata [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_rdata;
    logic [NUM_WAYS-1:0] store_we;

    logic [NUM_SETS-1:0] age_q;                 // per set, way to replace next
    logic                replace_way;
    logic                fill_we;
    logic                flush_pass;

    logic [TAG_W-1:0]    fwd_tag_q;             // last filled line, for the REFILL cycle
    logic [INDEX_W-1:0]  fwd_index_q;
    logic                fwd_way_q;

    logic [TAG_W-1:0]    way_tag   [NUM_WAYS];
    logic [LINE_W-1:0]   way_line  [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_hit;
    logic                hit, miss;

    function automatic logic [DATA_W-1:0] line_word(input logic [LINE_W-1:0]   line,
                                                    input logic [OFFSET_W-1:0] offset);
        line_word = line[offset*DATA_W +: DATA_W]; // word 0 in the low bits
    endfunction

    // ****************************************
    // request capture
    // ****************************************
    assign req_d   = cpu_cyc_i & cpu_stb_i & ~cpu_stall_o;
    assign index_d = cpu_addr_i[OFFSET_W +: INDEX_W];
    assign {tag_q, index_q, offset_q} = cpu_addr_q;

    always_ff @(posedge clk_i) begin
        if (req_d) begin
            cpu_addr_q <= cpu_addr_i;
        end
    end

    // ****************************************
    // tag, line and valid stores
    // ****************************************
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        assign store_we[w] = fill_we & (replace_way == w);

        sdp_mem #(.DW(TAG_W), .AW(INDEX_W)) i_tag_mem (
            .clk_i     (clk_i),
            .en_a_i    (req_d),
            .addr_a_i  (index_d),
            .rdata_a_o (tag_rdata[w]),
            .en_b_i    (store_we[w]),
            .addr_b_i  (index_q),
            .wdata_b_i (tag_q)
        );

        sdp_mem #(.DW(LINE_W), .AW(INDEX_W)) i_line_mem (
            .clk_i     (clk_i),
            .en_a_i    (req_d),
            .addr_a_i  (index_d),
            .rdata_a_o (line_rdata[w]),
            .en_b_i    (store_we[w]),
            .addr_b_i  (index_q),
            .wdata_b_i (fill_line_i)
        );
    end

    icache_valid_store i_valid_store (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_pass),
        .re_i    (req_d),
        .raddr_i (index_d),
        .rdata_o (valid_rdata),
        .we_i    (store_we),
        .waddr_i (index_q),
        .wdata_i (1'b1)
    );

    // flush only between transactions
    assign flush_pass = flush_i & (state_q == RUNNING) & ~req_q;

    // ****************************************
    // hit decision
    // ****************************************
    // a request taken in the fill cycle read the stores before the write landed
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_tag[w]   = tag_rdata[w];
            way_line[w]  = line_rdata[w];
            way_valid[w] = valid_rdata[w];
        end
        if (state_q == REFILL && fwd_index_q == index_q) begin
            way_tag[fwd_way_q]   = fwd_tag_q;
            way_line[fwd_way_q]  = fill_line_i;
            way_valid[fwd_way_q] = 1'b1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign way_hit[w] = way_valid[w] & (way_tag[w] == tag_q);
    end

    assign hit  = req_q & (|way_hit);
    assign miss = req_q & ~(|way_hit);

    // ****************************************
    // miss FSM
    // ****************************************
    always_comb begin
        state_d     = state_q;
        cpu_stall_o = 1'b0;
        fill_req_o  = 1'b0;
        fill_we     = 1'b0;
        unique case (state_q)
            RUNNING, REFILL: begin
                state_d = RUNNING;
                if (miss) begin
                    cpu_stall_o = 1'b1; // nothing accepted in the decision cycle
                    fill_req_o  = 1'b1;
                    state_d     = WAIT_MEMORY;
                end
            end
            WAIT_MEMORY: begin
                cpu_stall_o = ~fill_done_i; // drops with the restart ack
                if (fill_done_i) begin
                    fill_we = 1'b1;
                    state_d = REFILL;
                end
            end
            default: state_d = RUNNING;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= RUNNING;
            req_q   <= 1'b0;
            age_q   <= '0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
            if (fill_we) begin
                age_q[index_q] <= ~replace_way; // other way is older now
            end
        end
    end

    assign replace_way = age_q[index_q];

    always_ff @(posedge clk_i) begin
        if (fill_we) begin
            fwd_tag_q   <= tag_q;
            fwd_index_q <= index_q;
            fwd_way_q   <= replace_way;
        end
    end

    assign fill_addr_o = cpu_addr_q[CPU_AW-1:OFFSET_W];

    // response, early restart word or hit word
    assign cpu_ack_o   = hit | fill_we;
    assign cpu_rdata_o = fill_we ? line_word(fill_line_i, offset_q)
                                 : line_word(way_line[way_hit[1]], offset_q);

endmodule

// File: src/sdp_mem.sv
/*
 * simple dual-port memory
 * port a reads with one cycle latency, port b writes
 */

`timescale 1ns/10ps

module sdp_mem #(
    parameter int unsigned DW = 32,
    parameter int unsigned AW = 6
) (
    input  logic          clk_i,

    input  logic          en_a_i,
    input  logic [AW-1:0] addr_a_i,
    output logic [DW-1:0] rdata_a_o,

    input  logic          en_b_i,
    input  logic [AW-1:0] addr_b_i,
    input  logic [DW-1:0] wdata_b_i
);

    logic [DW-1:0] mem_q [0:(1<<AW)-1];
    logic [DW-1:0] rdata_q;

    initial mem_q = '{default: '0}; // array starts cleared

    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            rdata_q <= mem_q[addr_a_i]; // old data on a same-address write
        end
        if (en_b_i) begin
            mem_q[addr_b_i] <= wdata_b_i;
        end
    end

    assign rdata_a_o = rdata_q;

endmodule

// File: tb.f
src/icache_pkg.sv
src/sdp_mem.sv
src/icache_valid_store.sv
src/icache_refill.sv
src/instruction_cache.sv
src/icache_top.sv
verif/tb_icache_mem.sv
verif/tb_icache.sv

// File: verif/tb_icache.sv
/*
 * testbench for the instruction cache
 * random fetches over a few tags and sets, checked against a shadow cache model
 */

`timescale 1ns/10ps

module tb_icache import icache_pkg::*; ();

    localparam logic [31:0]      SEED       = 32'ha352;
    localparam int unsigned      NUM_ACCESS = 400;
    localparam int unsigned      NUM_TAGS   = 3;     // address range, tags per set
    localparam logic [TAG_W-1:0] TAG_STEP   = 22'h0_35b1;
    localparam int unsigned      SET_STEP   = 13;    // four sets 0, 13, 26, 39
    localparam int unsigned      STALL_RATE = 64;

    // ****************************************
    // run length limit
    // ****************************************
    localparam int unsigned MISS_CYCLES    = 32;
    localparam int unsigned GAP_CYCLES     = 4;
    localparam int unsigned FLUSH_CYCLES   = 3;
    localparam int unsigned TIMEOUT_CYCLES =
        NUM_ACCESS * (MISS_CYCLES + GAP_CYCLES + FLUSH_CYCLES) + 100;

    logic              clk_i, rstn_i, flush_i;
    logic              cpu_cyc_i, cpu_stb_i, cpu_stall_o, cpu_ack_o;
    logic [CPU_AW-1:0] cpu_addr_i;
    logic [DATA_W-1:0] cpu_rdata_o;
    logic              mem_cyc_o, mem_stb_o, mem_stall_i, mem_ack_i;
    logic [MEM_AW-1:0] mem_addr_o;
    logic [LINE_W-1:0] mem_rdata_i;

    int unsigned       cycle = 0;
    int unsigned       errors = 0;
    int unsigned       hits = 0;
    int unsigned       misses = 0;
    int unsigned       mem_reqs = 0;  // requests seen for the oldest access
    logic              mem_acked = 1'b0; // line is back for the oldest access

    logic [CPU_AW-1:0] q_addr [$];    // accepted, not yet acked
    bit                q_miss [$];
    int unsigned       q_cyc  [$];

    logic [TAG_W-1:0]    sh_tag   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] sh_valid [NUM_SETS];
    logic                sh_age   [NUM_SETS];

    icache_top i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cpu_cyc_i   (cpu_cyc_i),
        .cpu_stb_i   (cpu_stb_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_stall_o (cpu_stall_o),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .mem_cyc_o   (mem_cyc_o),
        .mem_stb_o   (mem_stb_o),
        .mem_addr_o  (mem_addr_o),
        .mem_stall_i (mem_stall_i),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .flush_i     (flush_i)
    );

    tb_icache_mem #(.SEED(SEED), .STALL_RATE(STALL_RATE)) i_mem (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .mem_cyc_i   (mem_cyc_o),
        .mem_stb_i   (mem_stb_o),
        .mem_addr_i  (mem_addr_o),
        .mem_stall_o (mem_stall_i),
        .mem_ack_o   (mem_ack_i),
        .mem_rdata_o (mem_rdata_i)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        next_rand = s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [CPU_AW-1:0] a);
        expected_word = (32'(a) * 32'h9e37_79b1) ^ 32'h0bad_c0de;
    endfunction

    function automatic logic [CPU_AW-1:0] pick_addr(input logic [31:0] r);
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] idx;
        tag = TAG_W'(r[21:20] % NUM_TAGS) * TAG_STEP + 1'b1;
        idx = INDEX_W'(r[19:18] * SET_STEP);
        pick_addr = {tag, idx, r[17:16]};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("Fail %s expected %h got %h at cycle %0d", name, exp, act, cycle);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at cycle %0d: %s", cycle, msg);
    endtask

    task automatic wait_for_ack();
        do @(posedge clk_i); while (!cpu_ack_o);
    endtask

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles, %0d errors",
                     TIMEOUT_CYCLES, errors);
            $display("Regression failed");
            $finish;
        end
    end

    // ****************************************
    // reference model and checks
    // ****************************************
    always @(posedge clk_i) begin : monitor
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] idx;
        logic               hit;
        logic               miss_wait;
        logic               mem_phase;
        logic               exp_stall;
        logic               exp_stb;
        if (!rstn_i) begin
            sh_valid  = '{default: '0};
            sh_age    = '{default: 1'b0};
            mem_acked = 1'b0;
        end else begin
            if (flush_i) begin
                sh_valid = '{default: '0}; // only pulsed between transactions
            end
            // a miss waits from its decision cycle until the cycle after the memory ack
            miss_wait = (q_addr.size() > 0) && q_miss[0] && (cycle > q_cyc[0]);
            exp_stall = miss_wait && !mem_acked;
            if (cpu_stall_o !== exp_stall)
                report_mismatch("cpu_stall_o", 32'(exp_stall), 32'(cpu_stall_o));
            if (miss_wait && cpu_ack_o !== mem_acked)
                report_mismatch("cpu_ack_o", 32'(mem_acked), 32'(cpu_ack_o));
            // bus cycle opens after the decision cycle and closes with the memory ack
            mem_phase = miss_wait && (cycle > q_cyc[0] + 1) && !mem_acked;
            exp_stb   = mem_phase && (mem_reqs == 0);
            if (mem_cyc_o !== mem_phase)
                report_mismatch("mem_cyc_o", 32'(mem_phase), 32'(mem_cyc_o));
            if (mem_stb_o !== exp_stb)
                report_mismatch("mem_stb_o", 32'(exp_stb), 32'(mem_stb_o));
            if (mem_stb_o && !mem_stall_i) begin
                if (q_addr.size() == 0 || !q_miss[0]) begin
                    report_error("memory request while no miss is pending");
                end else begin
                    mem_reqs++;
                    if (mem_addr_o !== q_addr[0][CPU_AW-1:OFFSET_W])
                        report_mismatch("mem_addr_o", 32'(q_addr[0][CPU_AW-1:OFFSET_W]),
                                        32'(mem_addr_o));
                end
            end
            if (mem_ack_i)
                mem_acked = 1'b1;
            if (cpu_ack_o) begin
                if (q_addr.size() == 0) begin
                    report_error("ack with no request outstanding");
                end else begin
                    if (cpu_rdata_o !== expected_word(q_addr[0]))
                        report_mismatch("cpu_rdata_o", expected_word(q_addr[0]), cpu_rdata_o);
                    if (q_miss[0] && mem_reqs != 1)
                        report_error($sformatf("miss saw %0d memory requests", mem_reqs));
                    if (!q_miss[0] && cycle != q_cyc[0] + 1)
                        report_error("hit was not acked one cycle after acceptance");
                    void'(q_addr.pop_front());
                    void'(q_miss.pop_front());
                    void'(q_cyc.pop_front());
                    mem_reqs  = 0;
                    mem_acked = 1'b0;
                end
            end
            if (cpu_cyc_i && cpu_stb_i && !cpu_stall_o) begin
                {tag, idx} = cpu_addr_i[CPU_AW-1:OFFSET_W];
                hit = 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (sh_valid[idx][w] && sh_tag[idx][w] == tag) hit = 1'b1;
                end
                if (hit) begin
                    hits++;
                end else begin
                    misses++;
                    sh_tag[idx][sh_age[idx]]   = tag;  // fill the older way
                    sh_valid[idx][sh_age[idx]] = 1'b1;
                    sh_age[idx]                = ~sh_age[idx];
                end
                q_addr.push_back(cpu_addr_i);
                q_miss.push_back(!hit);
                q_cyc.push_back(cycle);
            end
        end
    end

    // ****************************************
    // stimulus
    // ****************************************
    initial begin : driver
        logic [31:0] r;
        r          = SEED;
        clk_i      = 1'b0;
        rstn_i     = 1'b0;
        flush_i    = 1'b0;
        cpu_cyc_i  = 1'b0;
        cpu_stb_i  = 1'b0;
        cpu_addr_i = '0;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int n = 0; n < NUM_ACCESS; n++) begin
            r = next_rand(r);
            if (r[31:27] == 0 && n > 0) begin
                cpu_cyc_i <= 1'b0;
                cpu_stb_i <= 1'b0;
                wait_for_ack();
                @(posedge clk_i);    // past the cycle after a fill
                flush_i <= 1'b1;
                @(posedge clk_i);
                flush_i <= 1'b0;
            end else if (r[26:25] == 0) begin
                cpu_cyc_i <= 1'b0;   // idle gap
                cpu_stb_i <= 1'b0;
                repeat (r[24:23] + 1) @(posedge clk_i);
            end
            cpu_cyc_i  <= 1'b1;
            cpu_stb_i  <= 1'b1;
            cpu_addr_i <= pick_addr(r);
            @(posedge clk_i);
            while (cpu_stall_o) @(posedge clk_i);
        end
        cpu_cyc_i <= 1'b0;
        cpu_stb_i <= 1'b0;
        wait_for_ack();
        @(posedge clk_i);
        @(negedge clk_i);
        if (q_addr.size() != 0) report_error("accesses left without an ack");
        $display("%0d accesses, %0d hits, %0d misses, %0d errors",
                 NUM_ACCESS, hits, misses, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_icache_mem.sv
/*
 * behavioural backing memory for the instruction cache testbench
 * random stall and ack latency, line contents computed from the address
 */

`timescale 1ns/10ps

module tb_icache_mem import icache_pkg::*; #(
    parameter logic [31:0] SEED       = 32'h1,
    parameter int unsigned STALL_RATE = 64    // out of 256 cycles
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              mem_cyc_i,
    input  logic              mem_stb_i,
    input  logic [MEM_AW-1:0] mem_addr_i,
    output logic              mem_stall_o,
    output logic              mem_ack_o,
    output logic [LINE_W-1:0] mem_rdata_o
);

    logic [31:0]       rnd_q;
    logic              busy_q;
    logic [1:0]        wait_q;   // extra ack latency
    logic [MEM_AW-1:0] addr_q;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        next_rand = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every word is a scramble of its own word address, word 0 in the low bits
    function automatic logic [LINE_W-1:0] line_data(input logic [MEM_AW-1:0] la);
        logic [CPU_AW-1:0] wa;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            wa = {la, OFFSET_W'(k)};
            line_data[k*DATA_W +: DATA_W] = (32'(wa) * 32'h9e37_79b1) ^ 32'h0bad_c0de;
        end
    endfunction

    // quiet bus before the first reset edge
    initial begin
        mem_stall_o = 1'b0;
        mem_ack_o   = 1'b0;
        mem_rdata_o = '0;
    end

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            rnd_q       <= SEED;
            busy_q      <= 1'b0;
            wait_q      <= '0;
            mem_stall_o <= 1'b0;
            mem_ack_o   <= 1'b0;
            mem_rdata_o <= '0;
        end else begin
            rnd_q       <= next_rand(rnd_q);
            mem_ack_o   <= 1'b0;
            mem_stall_o <= (rnd_q[23:16] < STALL_RATE);
            if (!busy_q && mem_cyc_i && mem_stb_i && !mem_stall_o) begin
                busy_q <= 1'b1;          // request taken
                addr_q <= mem_addr_i;
                wait_q <= rnd_q[29:28];
            end else if (busy_q) begin
                if (wait_q == 0) begin
                    busy_q      <= 1'b0;
                    mem_ack_o   <= 1'b1;
                    mem_rdata_o <= line_data(addr_q);
                end else begin
                    wait_q <= wait_q - 1'b1;
                end
            end
        end
    end

endmodule
